//--- design/mips_types_pkg.sv
`default_nettype none

package mips_types_pkg;

	// data memory geometry, in 32-bit words
	localparam int DMEM_AW = 8;
	localparam int DMEM_DEPTH = 1 << DMEM_AW;

	// data or address word
	typedef logic [31:0] word_t;

	// general register index
	typedef logic [4:0] reg_addr_t;

	// byte strobe, bit k covers bits 8k+7 to 8k
	typedef logic [3:0] byte_en_t;

	// byte offset inside a word
	typedef logic [1:0] byte_off_t;

	// word index into the data memory
	typedef logic [DMEM_AW-1:0] mem_addr_t;

endpackage

`default_nettype wire

//--- design/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

	localparam int MEMOP_W = 10;

	// one-hot memory operation, all zero means no access
	typedef logic [MEMOP_W-1:0] memop_t;

	// full and sub-word loads
	localparam int MEMOP_LB = 0;
	localparam int MEMOP_LBU = 1;
	localparam int MEMOP_LH = 2;
	localparam int MEMOP_LHU = 3;
	localparam int MEMOP_LW = 4;

	// stores
	localparam int MEMOP_SB = 5;
	localparam int MEMOP_SH = 6;
	localparam int MEMOP_SW = 7;

	// unaligned partial loads
	localparam int MEMOP_LWL = 8;
	localparam int MEMOP_LWR = 9;

	// every bit that writes a loaded value back
	localparam memop_t MEMOP_LOAD_MASK = memop_t'(10'b11_0001_1111);

endpackage

`default_nettype wire

//--- design/exmem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module exmem_reg import mips_types_pkg::*, mem_op_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic stall_i,

	// from the execute stage
	input wire memop_t ex_memop_i,
	input wire word_t ex_addr_i,
	input wire word_t ex_store_data_i,
	input wire reg_addr_t ex_waddr_i,
	input wire word_t ex_wdata_i,
	input wire byte_en_t ex_wren_i,
	input wire word_t ex_pc_i,
	input wire word_t ex_inst_i,

	// data memory request
	output mem_addr_t dmem_addr_o,
	output byte_en_t dmem_wen_o,
	output word_t dmem_wdata_o,

	// registered fields for the memory stage
	output memop_t mem_memop_o,
	output byte_off_t mem_byte_off_o,
	output logic mem_is_load_o,
	output reg_addr_t mem_waddr_o,
	output word_t mem_wdata_o,
	output byte_en_t mem_wren_o,
	output word_t mem_pc_o,
	output word_t mem_inst_o
);

	byte_off_t ex_off;
	logic ex_is_load;
	word_t st_data;
	byte_en_t st_wen;

	assign ex_off = ex_addr_i[1:0];
	assign ex_is_load = |(ex_memop_i & MEMOP_LOAD_MASK);

	// replicate the store value into every lane it may land in
	always_comb begin
		st_data = ex_store_data_i;
		st_wen = '0;
		if (ex_memop_i[MEMOP_SB]) begin
			st_data = {4{ex_store_data_i[7:0]}};
			st_wen = 4'b0001 << ex_off;
		end else if (ex_memop_i[MEMOP_SH]) begin
			st_data = {2{ex_store_data_i[15:0]}};
			// halfwords are aligned, so only addr[1] picks the pair
			st_wen = ex_off[1] ? 4'b1100 : 4'b0011;
		end else if (ex_memop_i[MEMOP_SW]) begin
			st_data = ex_store_data_i;
			st_wen = 4'b1111;
		end
	end

	assign dmem_addr_o = ex_addr_i[DMEM_AW+1:2];
	assign dmem_wdata_o = st_data;
	// a frozen store must not hit the memory twice
	assign dmem_wen_o = stall_i ? '0 : st_wen;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_memop_o <= '0;
			mem_byte_off_o <= '0;
			mem_is_load_o <= 1'b0;
			mem_waddr_o <= '0;
			mem_wdata_o <= '0;
			mem_wren_o <= '0;
			mem_pc_o <= '0;
			mem_inst_o <= '0;
		end else if (!stall_i) begin
			mem_memop_o <= ex_memop_i;
			mem_byte_off_o <= ex_off;
			mem_is_load_o <= ex_is_load;
			mem_waddr_o <= ex_waddr_i;
			mem_wdata_o <= ex_wdata_i;
			mem_wren_o <= ex_wren_i;
			mem_pc_o <= ex_pc_i;
			mem_inst_o <= ex_inst_i;
		end
	end

endmodule

`default_nettype wire

//--- design/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram import mips_types_pkg::*;
(
	input wire logic clk,
	input wire logic stall_i,

	input wire mem_addr_t addr_i,
	input wire byte_en_t wen_i,
	input wire word_t wdata_i,

	output word_t rdata_o
);

	// each word kept as four byte lanes
	logic [3:0][7:0] mem_q [DMEM_DEPTH];

	always_ff @(posedge clk) begin
		for (int k = 0; k < 4; k++) begin
			if (wen_i[k]) begin
				mem_q[addr_i][k] <= wdata_i[8*k +: 8];
			end
		end
	end

	// read-before-write on the same address, output frozen while stalled
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			rdata_o <= mem_q[addr_i];
		end
	end

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mips_types_pkg::*, mem_op_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic stall_i,
	input wire logic flush_i,

	// word read from the data memory
	input wire word_t mem_memdata_i,

	input wire memop_t mem_memop_i,
	input wire byte_off_t mem_byte_off_i,
	input wire logic mem_is_load_i,
	input wire reg_addr_t mem_waddr_i,
	input wire word_t mem_wdata_i,
	input wire byte_en_t mem_wren_i,
	input wire word_t mem_pc_i,
	input wire word_t mem_inst_i,

	output reg_addr_t wb_waddr_o,
	output word_t wb_wdata_o,
	output byte_en_t wb_wren_o,
	output word_t wb_pc_o,
	output word_t wb_inst_o
);

	logic [7:0] sel_byte;
	logic [15:0] sel_half;
	word_t lb_res;
	word_t lbu_res;
	word_t lh_res;
	word_t lhu_res;
	word_t lwl_res;
	word_t lwr_res;
	word_t load_res;
	byte_en_t lwl_wren;
	byte_en_t lwr_wren;

	word_t wb_inst_d;
	reg_addr_t wb_waddr_d;
	word_t wb_wdata_d;
	byte_en_t wb_wren_d;

	// per-offset lane pick, merge shifts and partial strobes
	always_comb begin
		case (mem_byte_off_i)
			2'd0: begin
				sel_byte = mem_memdata_i[7:0];
				lwl_res = {mem_memdata_i[7:0], 24'b0};
				lwr_res = mem_memdata_i;
				lwl_wren = 4'b1000;
				lwr_wren = 4'b1111;
			end
			2'd1: begin
				sel_byte = mem_memdata_i[15:8];
				lwl_res = {mem_memdata_i[15:0], 16'b0};
				lwr_res = {8'b0, mem_memdata_i[31:8]};
				lwl_wren = 4'b1100;
				lwr_wren = 4'b0111;
			end
			2'd2: begin
				sel_byte = mem_memdata_i[23:16];
				lwl_res = {mem_memdata_i[23:0], 8'b0};
				lwr_res = {16'b0, mem_memdata_i[31:16]};
				lwl_wren = 4'b1110;
				lwr_wren = 4'b0011;
			end
			default: begin
				sel_byte = mem_memdata_i[31:24];
				lwl_res = mem_memdata_i;
				lwr_res = {24'b0, mem_memdata_i[31:24]};
				lwl_wren = 4'b1111;
				lwr_wren = 4'b0001;
			end
		endcase
	end

	// halfwords are aligned, any nonzero offset means the upper half
	assign sel_half = (mem_byte_off_i == 2'd0) ? mem_memdata_i[15:0] : mem_memdata_i[31:16];

	assign lb_res = {{24{sel_byte[7]}}, sel_byte};
	assign lbu_res = {24'b0, sel_byte};
	assign lh_res = {{16{sel_half[15]}}, sel_half};
	assign lhu_res = {16'b0, sel_half};

	// memop is one-hot, so the masked terms never overlap
	assign load_res = ({32{mem_memop_i[MEMOP_LB]}} & lb_res)
		| ({32{mem_memop_i[MEMOP_LBU]}} & lbu_res)
		| ({32{mem_memop_i[MEMOP_LH]}} & lh_res)
		| ({32{mem_memop_i[MEMOP_LHU]}} & lhu_res)
		| ({32{mem_memop_i[MEMOP_LW]}} & mem_memdata_i)
		| ({32{mem_memop_i[MEMOP_LWL]}} & lwl_res)
		| ({32{mem_memop_i[MEMOP_LWR]}} & lwr_res);

	// flush squashes everything but the pc
	assign wb_inst_d = flush_i ? '0 : mem_inst_i;
	assign wb_waddr_d = flush_i ? '0 : mem_waddr_i;
	assign wb_wdata_d = flush_i ? '0 : (mem_is_load_i ? load_res : mem_wdata_i);
	assign wb_wren_d = flush_i ? '0 :
		mem_memop_i[MEMOP_LWL] ? lwl_wren :
		mem_memop_i[MEMOP_LWR] ? lwr_wren :
		mem_wren_i;

	// MEM/WB register
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_inst_o <= '0;
			wb_waddr_o <= '0;
			wb_wdata_o <= '0;
			wb_wren_o <= '0;
			wb_pc_o <= '0;
		end else if (!stall_i) begin
			wb_inst_o <= wb_inst_d;
			wb_waddr_o <= wb_waddr_d;
			wb_wdata_o <= wb_wdata_d;
			wb_wren_o <= wb_wren_d;
			wb_pc_o <= mem_pc_i;
		end
	end

endmodule

`default_nettype wire

//--- design/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mips_types_pkg::*, mem_op_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic stall_i,
	input wire logic flush_i,

	input wire memop_t ex_memop_i,
	input wire word_t ex_addr_i,
	input wire word_t ex_store_data_i,
	input wire reg_addr_t ex_waddr_i,
	input wire word_t ex_wdata_i,
	input wire byte_en_t ex_wren_i,
	input wire word_t ex_pc_i,
	input wire word_t ex_inst_i,

	// forwarding tap on the EX/MEM result
	output word_t mem_wdata_bp_o,

	output reg_addr_t wb_waddr_o,
	output word_t wb_wdata_o,
	output byte_en_t wb_wren_o,
	output word_t wb_pc_o,
	output word_t wb_inst_o
);

	mem_addr_t dmem_addr;
	byte_en_t dmem_wen;
	word_t dmem_wdata;
	word_t dmem_rdata;

	memop_t mem_memop;
	byte_off_t mem_byte_off;
	logic mem_is_load;
	reg_addr_t mem_waddr;
	word_t mem_wdata;
	byte_en_t mem_wren;
	word_t mem_pc;
	word_t mem_inst;

	assign mem_wdata_bp_o = mem_wdata;

	exmem_reg u_exmem (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.stall_i(stall_i),
		.ex_memop_i(ex_memop_i),
		.ex_addr_i(ex_addr_i),
		.ex_store_data_i(ex_store_data_i),
		.ex_waddr_i(ex_waddr_i),
		.ex_wdata_i(ex_wdata_i),
		.ex_wren_i(ex_wren_i),
		.ex_pc_i(ex_pc_i),
		.ex_inst_i(ex_inst_i),
		.dmem_addr_o(dmem_addr),
		.dmem_wen_o(dmem_wen),
		.dmem_wdata_o(dmem_wdata),
		.mem_memop_o(mem_memop),
		.mem_byte_off_o(mem_byte_off),
		.mem_is_load_o(mem_is_load),
		.mem_waddr_o(mem_waddr),
		.mem_wdata_o(mem_wdata),
		.mem_wren_o(mem_wren),
		.mem_pc_o(mem_pc),
		.mem_inst_o(mem_inst)
	);

	data_sram u_dmem (
		.clk(clk),
		.stall_i(stall_i),
		.addr_i(dmem_addr),
		.wen_i(dmem_wen),
		.wdata_i(dmem_wdata),
		.rdata_o(dmem_rdata)
	);

	mem_stage u_mem (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.stall_i(stall_i),
		.flush_i(flush_i),
		.mem_memdata_i(dmem_rdata),
		.mem_memop_i(mem_memop),
		.mem_byte_off_i(mem_byte_off),
		.mem_is_load_i(mem_is_load),
		.mem_waddr_i(mem_waddr),
		.mem_wdata_i(mem_wdata),
		.mem_wren_i(mem_wren),
		.mem_pc_i(mem_pc),
		.mem_inst_i(mem_inst),
		.wb_waddr_o(wb_waddr_o),
		.wb_wdata_o(wb_wdata_o),
		.wb_wren_o(wb_wren_o),
		.wb_pc_o(wb_pc_o),
		.wb_inst_o(wb_inst_o)
	);

endmodule

`default_nettype wire

//--- tb/mem_subsys_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assertions import mips_types_pkg::*, mem_op_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic stall_i,
	input wire logic flush_i,
	input wire memop_t memop_i,
	input wire reg_addr_t wb_waddr_i,
	input wire word_t wb_wdata_i,
	input wire byte_en_t wb_wren_i,
	input wire word_t wb_pc_i,
	input wire word_t wb_inst_i
);

	// a squashed capture leaves no register write behind
	flush_clears_wren: assert property (@(posedge clk) disable iff (!rst_n_i)
		(flush_i && !stall_i) |=> (wb_wren_i == '0))
		else $error("write strobe not cleared after a flushed capture");

	// nothing moves across a stalled edge
	stall_holds_wb: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_i |=> ($stable(wb_waddr_i) && $stable(wb_wdata_i) && $stable(wb_wren_i)
			&& $stable(wb_pc_i) && $stable(wb_inst_i)))
		else $error("MEM/WB outputs changed across a stalled edge");

	memop_onehot: assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0(memop_i))
		else $error("memory operation vector is not one-hot");

endmodule

bind mem_stage mem_subsys_assertions u_chk (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.stall_i(stall_i),
	.flush_i(flush_i),
	.memop_i(mem_memop_i),
	.wb_waddr_i(wb_waddr_o),
	.wb_wdata_i(wb_wdata_o),
	.wb_wren_i(wb_wren_o),
	.wb_pc_i(wb_pc_o),
	.wb_inst_i(wb_inst_o)
);

`default_nettype wire

//--- tb/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mips_types_pkg::*, mem_op_pkg::*;
();

	localparam int N_OPS = 3000;
	localparam int WINDOW_WORDS = 64;
	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 4;
	// four clock periods of slack for every issued cycle
	localparam int WATCHDOG_NS = (WINDOW_WORDS + N_OPS + RESET_CYCLES + DRAIN_CYCLES) * 40;

	// named after the DUT ports, connected by .*
	logic clk;
	logic rst_n_i;
	logic stall_i;
	logic flush_i;
	memop_t ex_memop_i;
	word_t ex_addr_i;
	word_t ex_store_data_i;
	reg_addr_t ex_waddr_i;
	word_t ex_wdata_i;
	byte_en_t ex_wren_i;
	word_t ex_pc_i;
	word_t ex_inst_i;
	word_t mem_wdata_bp_o;
	reg_addr_t wb_waddr_o;
	word_t wb_wdata_o;
	byte_en_t wb_wren_o;
	word_t wb_pc_o;
	word_t wb_inst_o;

	// model: byte memory, the EX/MEM entry and the expected MEM/WB entry
	logic [7:0] model_mem [int];
	memop_t m_memop = '0;
	byte_off_t m_off = '0;
	word_t m_read = '0;
	reg_addr_t m_waddr = '0;
	word_t m_wdata = '0;
	byte_en_t m_wren = '0;
	word_t m_pc = '0;
	word_t m_inst = '0;
	reg_addr_t exp_waddr = '0;
	word_t exp_wdata = '0;
	byte_en_t exp_wren = '0;
	word_t exp_pc = '0;
	word_t exp_inst = '0;
	int check_cnt = 0;
	int mismatch_cnt = 0;

	mem_subsys_top dut0 (.*);

	always #5 clk = ~clk;

	task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			mismatch_cnt++;
			$display("MISMATCH t=%0t %s expected %08h actual %08h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_strobe(input string name, input byte_en_t exp_v, input byte_en_t act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			mismatch_cnt++;
			$display("MISMATCH t=%0t %s expected %04b actual %04b", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_reg_addr(input string name, input reg_addr_t exp_v, input reg_addr_t act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			mismatch_cnt++;
			$display("MISMATCH t=%0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_outputs();
		check_word("wb_wdata_o", exp_wdata, wb_wdata_o);
		check_word("wb_pc_o", exp_pc, wb_pc_o);
		check_word("wb_inst_o", exp_inst, wb_inst_o);
		check_word("mem_wdata_bp_o", m_wdata, mem_wdata_bp_o);
		check_strobe("wb_wren_o", exp_wren, wb_wren_o);
		check_reg_addr("wb_waddr_o", exp_waddr, wb_waddr_o);
	endtask

	function automatic word_t model_word(int widx);
		word_t w;
		for (int k = 0; k < 4; k++) begin
			w[8*k +: 8] = model_mem.exists(4 * widx + k) ? model_mem[4 * widx + k] : 8'h00;
		end
		return w;
	endfunction

	function automatic logic is_load(memop_t op);
		return op[MEMOP_LB] | op[MEMOP_LBU] | op[MEMOP_LH] | op[MEMOP_LHU] | op[MEMOP_LW]
			| op[MEMOP_LWL] | op[MEMOP_LWR];
	endfunction

	// little-endian lane rules for each load kind
	function automatic word_t expect_load(memop_t op, word_t w, byte_off_t off);
		int o;
		logic [7:0] b;
		logic [15:0] h;
		o = int'(off);
		b = w[8*o +: 8];
		h = off[1] ? w[31:16] : w[15:0];
		if (op[MEMOP_LB]) return {{24{b[7]}}, b};
		if (op[MEMOP_LBU]) return {24'h0, b};
		if (op[MEMOP_LH]) return {{16{h[15]}}, h};
		if (op[MEMOP_LHU]) return {16'h0, h};
		if (op[MEMOP_LWL]) return w << (8 * (3 - o));
		if (op[MEMOP_LWR]) return w >> (8 * o);
		return w;
	endfunction

	function automatic byte_en_t expect_wren(memop_t op, byte_off_t off, byte_en_t wren);
		if (op[MEMOP_LWL]) return 4'b1111 << (3 - int'(off));
		if (op[MEMOP_LWR]) return 4'b1111 >> off;
		return wren;
	endfunction

	// one unstalled rising edge of the whole slice
	task automatic model_step();
		int widx;
		int base;
		if (stall_i) begin
			return;
		end
		exp_pc = m_pc;
		if (flush_i) begin
			exp_inst = '0;
			exp_waddr = '0;
			exp_wdata = '0;
			exp_wren = '0;
		end else begin
			exp_inst = m_inst;
			exp_waddr = m_waddr;
			exp_wdata = is_load(m_memop) ? expect_load(m_memop, m_read, m_off) : m_wdata;
			exp_wren = expect_wren(m_memop, m_off, m_wren);
		end
		// the read returns the word as it was before this edge's store
		widx = int'(ex_addr_i[DMEM_AW+1:2]);
		base = 4 * widx;
		m_read = model_word(widx);
		m_memop = ex_memop_i;
		m_off = ex_addr_i[1:0];
		m_waddr = ex_waddr_i;
		m_wdata = ex_wdata_i;
		m_wren = ex_wren_i;
		m_pc = ex_pc_i;
		m_inst = ex_inst_i;
		if (ex_memop_i[MEMOP_SB]) begin
			model_mem[base + int'(ex_addr_i[1:0])] = ex_store_data_i[7:0];
		end else if (ex_memop_i[MEMOP_SH]) begin
			model_mem[base + 2 * int'(ex_addr_i[1])] = ex_store_data_i[7:0];
			model_mem[base + 2 * int'(ex_addr_i[1]) + 1] = ex_store_data_i[15:8];
		end else if (ex_memop_i[MEMOP_SW]) begin
			for (int k = 0; k < 4; k++) begin
				model_mem[base + k] = ex_store_data_i[8*k +: 8];
			end
		end
	endtask

	// drive on the falling edge, model the rising edge, check at the next falling edge
	task automatic run_cycle(input memop_t op, input word_t addr, input logic st, input logic fl);
		ex_memop_i = op;
		ex_addr_i = addr;
		ex_store_data_i = $urandom();
		ex_waddr_i = reg_addr_t'($urandom());
		ex_wdata_i = $urandom();
		ex_wren_i = byte_en_t'($urandom());
		ex_pc_i = $urandom();
		ex_inst_i = $urandom();
		stall_i = st;
		flush_i = fl;
		@(posedge clk);
		model_step();
		@(negedge clk);
		check_outputs();
	endtask

	initial begin
		memop_t op;
		word_t addr;
		int pick;
		void'($urandom(32'hfb4428dd));
		clk = 1'b0;
		rst_n_i = 1'b0;
		stall_i = 1'b0;
		flush_i = 1'b0;
		ex_memop_i = '0;
		ex_addr_i = '0;
		ex_store_data_i = '0;
		ex_waddr_i = '0;
		ex_wdata_i = '0;
		ex_wren_i = '0;
		ex_pc_i = '0;
		ex_inst_i = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n_i = 1'b1;
		check_outputs();
		// known contents over the whole test window first
		for (int i = 0; i < WINDOW_WORDS; i++) begin
			run_cycle(memop_t'(1) << MEMOP_SW, word_t'(i) << 2, 1'b0, 1'b0);
		end
		for (int i = 0; i < N_OPS; i++) begin
			pick = $urandom_range(0, 12);
			op = (pick < MEMOP_W) ? memop_t'(1) << pick : '0;
			addr = word_t'($urandom_range(0, 4 * WINDOW_WORDS - 1));
			if (op[MEMOP_LH] || op[MEMOP_LHU] || op[MEMOP_SH]) begin
				addr[0] = 1'b0;
			end
			if (op[MEMOP_LW] || op[MEMOP_SW]) begin
				addr[1:0] = 2'b00;
			end
			run_cycle(op, addr, $urandom_range(0, 99) < 15, $urandom_range(0, 99) < 10);
		end
		repeat (DRAIN_CYCLES) run_cycle('0, '0, 1'b0, 1'b0);
		$display("checks %0d, mismatches %0d", check_cnt, mismatch_cnt);
		if (mismatch_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: run did not finish within %0d ns, stopped by watchdog", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- mem_subsys.f
design/mips_types_pkg.sv
design/mem_op_pkg.sv
design/exmem_reg.sv
design/data_sram.sv
design/mem_stage.sv
design/mem_subsys_top.sv
tb/mem_subsys_assertions.sv
tb/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the memory slice testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_mem_subsys -f mem_subsys.f -o sim_mem_subsys

status=0
./obj_dir/sim_mem_subsys > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
